// File: cim_top.f
+incdir+verilog
verilog/cim_pkg.sv
verilog/cim_sram_if.sv
verilog/cim_compute_if.sv
verilog/cim_host_port.sv
verilog/cim_controller.sv
verilog/cim_sram_array.sv
verilog/cim_compute_unit.sv
verilog/cim_top.sv
verification/cim_top_tb.sv

// File: verification/cim_top_tb.sv
// Self-checking testbench for the compute-in-memory block
// Command table, row memory and carry reference model, Avalon host driver

`timescale 1ns/1ps
`include "cim_config.svh"

module cim_top_tb
    import cim_pkg::*;
();

    localparam logic [1:0] K_LOAD = 2'd0;
    localparam logic [1:0] K_EXEC = 2'd1;
    localparam logic [1:0] K_READ = 2'd2;

    typedef struct packed {
        logic [1:0] kind;
        logic [7:0] opcode;
        row_addr_t  s1;
        row_addr_t  s2;
        row_addr_t  d1;
        row_addr_t  addr;
        row_data_t  data;
    } entry_t;

    logic                            sys_clk_in;
    logic                            sys_reset_in;
    logic [`CIM_HOST_ADDR_WIDTH-1:0] avalon_address;
    logic [`CIM_DATA_WIDTH-1:0]      avalon_writedata;
    logic                            avalon_write;
    logic                            avalon_read;
    logic                            avalon_waitrequest;
    logic [`CIM_DATA_WIDTH-1:0]      avalon_readdata;
    logic                            avalon_readdatavalid;

    entry_t    table_q [$];
    string     name_q [$];
    row_data_t model_mem [`CIM_DEPTH];
    logic      model_carry;

    cim_top cim_top_i (
        .sys_clk_in           (sys_clk_in),
        .sys_reset_in         (sys_reset_in),
        .avalon_address       (avalon_address),
        .avalon_writedata     (avalon_writedata),
        .avalon_write         (avalon_write),
        .avalon_read          (avalon_read),
        .avalon_waitrequest   (avalon_waitrequest),
        .avalon_readdata      (avalon_readdata),
        .avalon_readdatavalid (avalon_readdatavalid)
    );

    initial
    begin
        sys_clk_in = 1'b0;
        forever #50 sys_clk_in = ~sys_clk_in;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping on timeout");
    endtask

    task automatic add_entry(input string name, input logic [1:0] kind,
                             input logic [7:0] opcode, input row_addr_t s1,
                             input row_addr_t s2, input row_addr_t d1,
                             input row_addr_t addr, input row_data_t data);
        table_q.push_back('{kind, opcode, s1, s2, d1, addr, data});
        name_q.push_back(name);
    endtask

    task automatic build_table();
        logic [31:0] rng;
        logic [19:0] amt_list;
        shift_amt_t  amt;
        int          k;
        rng      = 32'hf338;
        amt_list = {5'd31, 5'd17, 5'd1, 5'd0};
        // Random rows spread over the whole array, then read back
        for (k = 0; k < 16; k++)
        begin
            rng = next_random(rng);
            add_entry($sformatf("load %0d", k * 17), K_LOAD, 0, 0, 0, 0,
                      row_addr_t'(k * 17), rng);
        end
        for (k = 0; k < 16; k++)
            add_entry($sformatf("read %0d", k * 17), K_READ, 0, 0, 0, 0,
                      row_addr_t'(k * 17), 0);
        // One-operand ops write s2
        add_entry("move", K_EXEC, MOVE, 8'd17, 8'h01, 8'h00, 0, 0);
        add_entry("invert", K_EXEC, P_INV, 8'd34, 8'h02, 8'h00, 0, 0);
        for (k = 0; k < 4; k++)
        begin
            amt = amt_list[k*5 +: 5];
            add_entry($sformatf("lshift %0d", amt), K_EXEC, LSHFT, 8'd51,
                      row_addr_t'(3 + k), row_addr_t'(amt), 0, 0);
            add_entry($sformatf("rshift %0d", amt), K_EXEC, RSHFT, 8'd68,
                      row_addr_t'(7 + k), row_addr_t'(amt), 0, 0);
        end
        for (k = 1; k <= 10; k++)
            add_entry($sformatf("read result %0d", k), K_READ, 0, 0, 0, 0,
                      row_addr_t'(k), 0);
        // Sources must be untouched
        for (k = 1; k <= 4; k++)
            add_entry($sformatf("read source %0d", k * 17), K_READ, 0, 0, 0, 0,
                      row_addr_t'(k * 17), 0);
        add_entry("or", K_EXEC, ORC, 8'd85, 8'd102, 8'h10, 0, 0);
        add_entry("and", K_EXEC, ANDC, 8'd85, 8'd102, 8'h11, 0, 0);
        add_entry("xor", K_EXEC, XORC, 8'd85, 8'd102, 8'h12, 0, 0);
        add_entry("xor in place", K_EXEC, XORC, 8'd119, 8'd136, 8'd119, 0, 0);
        // Carry chain, second add overflows
        add_entry("set carry", K_EXEC, SCIN, 8'h01, 0, 0, 0, 0);
        add_entry("add carry in", K_EXEC, ADDS, 8'd153, 8'd170, 8'h20, 0, 0);
        add_entry("load big", K_LOAD, 0, 0, 0, 0, 8'h30, 32'hffff_fff0);
        add_entry("load small", K_LOAD, 0, 0, 0, 0, 8'h31, 32'h0000_0020);
        add_entry("add overflow", K_EXEC, ADDS, 8'h30, 8'h31, 8'h32, 0, 0);
        add_entry("add chained", K_EXEC, ADDS, 8'd187, 8'd204, 8'h33, 0, 0);
        add_entry("clear carry", K_EXEC, SCIN, 8'h02, 0, 0, 0, 0);
        add_entry("add no carry", K_EXEC, ADDS, 8'h30, 8'h30, 8'h34, 0, 0);
        add_entry("add after wrap", K_EXEC, ADDS, 8'd221, 8'd238, 8'h35, 0, 0);
        // Burst with dependent results
        rng = next_random(rng);
        add_entry("burst load a", K_LOAD, 0, 0, 0, 0, 8'h40, rng);
        rng = next_random(rng);
        add_entry("burst load b", K_LOAD, 0, 0, 0, 0, 8'h41, rng);
        add_entry("burst xor", K_EXEC, XORC, 8'h40, 8'h41, 8'h42, 0, 0);
        add_entry("burst add", K_EXEC, ADDS, 8'h40, 8'h41, 8'h43, 0, 0);
        add_entry("burst move", K_EXEC, MOVE, 8'h42, 8'h44, 8'h00, 0, 0);
        add_entry("burst shift", K_EXEC, LSHFT, 8'h43, 8'h45, 8'h03, 0, 0);
        for (k = 0; k < 12; k++)
            add_entry($sformatf("read check %0d", k), K_READ, 0, 0, 0, 0,
                      (k < 6) ? row_addr_t'(8'h30 + k) : row_addr_t'(8'h40 + k - 6), 0);
        for (k = 0; k < 5; k++)
            add_entry($sformatf("read logic %0d", k), K_READ, 0, 0, 0, 0,
                      (k < 3) ? row_addr_t'(8'h10 + k) : row_addr_t'(119 + (k - 3) * 17), 0);
        add_entry("read add carry in", K_READ, 0, 0, 0, 0, 8'h20, 0);
    endtask

    // Mirrors the row and carry rules, returns the row a read should see
    task automatic run_model(input entry_t e, output row_data_t expected);
        row_data_t   a;
        row_data_t   b;
        logic [32:0] sum;
        a        = model_mem[e.s1];
        b        = model_mem[e.s2];
        sum      = {1'b0, a} + {1'b0, b} + {32'b0, model_carry};
        expected = model_mem[e.addr];
        if (e.kind == K_LOAD)
            model_mem[e.addr] = e.data;
        else if (e.kind == K_EXEC)
        begin
            case (e.opcode)
                MOVE:    model_mem[e.s2] = a;
                P_INV:   model_mem[e.s2] = ~a;
                LSHFT:   model_mem[e.s2] = a << e.d1[4:0];
                RSHFT:   model_mem[e.s2] = a >> e.d1[4:0];
                ORC:     model_mem[e.d1] = a | b;
                ANDC:    model_mem[e.d1] = a & b;
                XORC:    model_mem[e.d1] = a ^ b;
                ADDS:
                begin
                    model_mem[e.d1] = sum[31:0];
                    model_carry     = sum[32];
                end
                SCIN:    model_carry = e.s1[0];
                default: ;
            endcase
        end
    endtask

    task automatic drive_request(input entry_t e);
        avalon_write     = (e.kind != K_READ);
        avalon_read      = (e.kind == K_READ);
        avalon_address   = {(e.kind == K_LOAD), e.addr};
        avalon_writedata = (e.kind == K_EXEC) ? {e.opcode, e.s1, e.s2, e.d1} : e.data;
    endtask

    task automatic drive_idle();
        avalon_write = 1'b0;
        avalon_read  = 1'b0;
    endtask

    // Counts the cycles a pending request is held off
    task automatic wait_ready(input string name, input int expected_hold);
        int cycles;
        cycles = 0;
        while (avalon_waitrequest)
        begin
            @(posedge sys_clk_in);
            #10;
            cycles++;
            check_equal({name, " readdatavalid"}, 0, avalon_readdatavalid);
            if (cycles > 20)
                report_timeout({name, ": waitrequest stayed high"});
        end
        check_equal({name, " hold-off cycles"}, expected_hold, cycles);
    endtask

    task automatic wait_readback(input string name, input row_data_t expected);
        int cycles;
        cycles = 0;
        while (!avalon_readdatavalid)
        begin
            @(posedge sys_clk_in);
            #10;
            cycles++;
            if (cycles > 20)
                report_timeout({name, ": readdatavalid never rose"});
        end
        check_equal({name, " latency"}, 3, cycles);
        check_equal(name, expected, avalon_readdata);
        check_equal({name, " waitrequest"}, 0, avalon_waitrequest);
        @(posedge sys_clk_in);
        #10;
        check_equal({name, " valid width"}, 0, avalon_readdatavalid);
    endtask

    initial
    begin
        entry_t    e;
        row_data_t expected;
        int        hold;
        int        i;
        sys_reset_in     = 1'b1;
        avalon_address   = '0;
        avalon_writedata = '0;
        avalon_write     = 1'b0;
        avalon_read      = 1'b0;
        model_carry      = 1'b0;
        build_table();
        repeat (4) @(posedge sys_clk_in);
        #10;
        check_equal("waitrequest in reset", 1, avalon_waitrequest);
        check_equal("readdatavalid in reset", 0, avalon_readdatavalid);
        sys_reset_in = 1'b0;
        wait_ready("reset release", 1);
        hold = 0;

        // Each request goes out right after the previous one is accepted
        for (i = 0; i < table_q.size(); i++)
        begin
            e = table_q[i];
            drive_request(e);
            wait_ready(name_q[i], hold);
            @(posedge sys_clk_in);
            #10;
            drive_idle();
            check_equal({name_q[i], " held off"}, 1, avalon_waitrequest);
            run_model(e, expected);
            if (e.kind == K_READ)
            begin
                wait_readback(name_q[i], expected);
                hold = 0;
            end
            else if (e.kind == K_LOAD || e.opcode == SCIN)
                hold = 1;
            else
                hold = 2;
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: verilog/cim_compute_if.sv
// Command bundle from controller to compute unit
// Operation select, shift count and carry flag controls

`timescale 1ns/1ps

interface cim_compute_if
    import cim_pkg::*;
();

    combine_op_t combine_op;
    shift_amt_t  shift_amount;
    // One-cycle strobes
    logic        update_carry;
    logic        load_carry;
    logic        carry_value;

    modport command (
        output combine_op,
        output shift_amount,
        output update_carry,
        output load_carry,
        output carry_value
    );

    modport unit (
        input combine_op,
        input shift_amount,
        input update_carry,
        input load_carry,
        input carry_value
    );

endinterface

// File: verilog/cim_compute_unit.sv
// Row compute datapath
// Bitwise combine, logical shifts, inversion, add with carry flag

`timescale 1ns/1ps

module cim_compute_unit
    import cim_pkg::*;
(
    input  logic       sys_clk_in,
    input  logic       sys_reset_in,
    cim_compute_if.unit cmd,
    input  row_data_t  rdata_a,
    input  row_data_t  rdata_b,
    output row_data_t  result
);

    logic      carry_flag;
    logic      add_carry;
    row_data_t add_sum;

    // Carry out lands in the extra top bit
    assign {add_carry, add_sum} = rdata_a + rdata_b + row_data_t'(carry_flag);

    always_comb
    begin
        case (cmd.combine_op)
            CMB_PASS: result = rdata_a;
            CMB_OR:   result = rdata_a | rdata_b;
            CMB_AND:  result = rdata_a & rdata_b;
            CMB_XOR:  result = rdata_a ^ rdata_b;
            CMB_SHL:  result = rdata_a << cmd.shift_amount;
            CMB_SHR:  result = rdata_a >> cmd.shift_amount;
            CMB_INV:  result = ~rdata_a;
            CMB_ADD:  result = add_sum;
            default:  result = rdata_a;
        endcase
    end

    always_ff @(posedge sys_clk_in or posedge sys_reset_in)
    begin
        if (sys_reset_in)
            carry_flag <= 1'b0;
        else if (cmd.load_carry)
            carry_flag <= cmd.carry_value;
        else if (cmd.update_carry)
            carry_flag <= add_carry;
    end

endmodule

// File: verilog/cim_config.svh
// Compute-in-memory block configuration
// Array geometry, host address width and instruction field positions

`ifndef CIM_CONFIG_SVH
`define CIM_CONFIG_SVH

// Array geometry
`define CIM_ADDR_WIDTH      8
`define CIM_DATA_WIDTH      32
`define CIM_HOST_ADDR_WIDTH 9
`define CIM_DEPTH           256

// Instruction word fields
`define CIM_OP_HI 31
`define CIM_OP_LO 24
`define CIM_S1_HI 23
`define CIM_S1_LO 16
`define CIM_S2_HI 15
`define CIM_S2_LO 8
`define CIM_D1_HI 7
`define CIM_D1_LO 0

`endif

// File: verilog/cim_controller.sv
// Instruction sequencer for the compute-in-memory block
// Load, readback, two-cycle execute and carry set state machine

`timescale 1ns/1ps

module cim_controller
    import cim_pkg::*;
(
    input  logic           sys_clk_in,
    input  logic           sys_reset_in,
    input  logic           load_start,
    input  logic           exec_start,
    input  logic           read_start,
    input  cim_opcode_t    opcode,
    input  row_addr_t      s1,
    input  row_addr_t      s2,
    input  row_addr_t      d1,
    input  row_addr_t      row_addr,
    output logic           ready,
    output logic           readback_strobe,
    cim_sram_if.driver     sram,
    cim_compute_if.command compute
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        two_operand;

    function automatic combine_op_t op_to_combine(input cim_opcode_t op);
        case (op)
            ORC:     return CMB_OR;
            ANDC:    return CMB_AND;
            XORC:    return CMB_XOR;
            LSHFT:   return CMB_SHL;
            RSHFT:   return CMB_SHR;
            P_INV:   return CMB_INV;
            ADDS:    return CMB_ADD;
            default: return CMB_PASS;
        endcase
    endfunction

    // Two-operand ops write d1, the rest write s2
    assign two_operand = (opcode == ORC) || (opcode == ANDC) ||
                         (opcode == XORC) || (opcode == ADDS);

    assign compute.combine_op   = op_to_combine(opcode);
    assign compute.shift_amount = d1[4:0];
    assign compute.carry_value  = s1[0];

    always_ff @(posedge sys_clk_in or posedge sys_reset_in)
    begin
        if (sys_reset_in)
        begin
            state <= IDLE;
            ready <= 1'b0;
        end
        else
        begin
            state <= next_state;
            ready <= (next_state == IDLE);
        end
    end

    always_comb
    begin
        next_state             = state;
        sram.addr_a            = s1;
        sram.addr_b            = s2;
        sram.wren_b            = 1'b0;
        sram.wsel_load         = 1'b0;
        readback_strobe        = 1'b0;
        compute.update_carry   = 1'b0;
        compute.load_carry     = 1'b0;

        case (state)
            IDLE:
            begin
                if (load_start)
                    next_state = LOAD;
                else if (read_start)
                    next_state = READ1;
                else if (exec_start)
                begin
                    case (opcode)
                        SCIN:    next_state = SETC;
                        MOVE, ORC, ANDC, XORC,
                        LSHFT, RSHFT, P_INV, ADDS:
                                 next_state = EXEC1;
                        // Unknown opcodes are accepted and dropped
                        default: next_state = IDLE;
                    endcase
                end
            end

            LOAD:
            begin
                sram.addr_b    = row_addr;
                sram.wren_b    = 1'b1;
                sram.wsel_load = 1'b1;
                next_state     = IDLE;
            end

            // Address held on port A until the data is registered out
            READ1:
            begin
                sram.addr_a = row_addr;
                next_state  = READ2;
            end

            READ2:
            begin
                sram.addr_a = row_addr;
                next_state  = READ3;
            end

            READ3:
            begin
                sram.addr_a     = row_addr;
                readback_strobe = 1'b1;
                next_state      = IDLE;
            end

            // Operand rows presented, data valid in EXEC2
            EXEC1:
            begin
                next_state = EXEC2;
            end

            EXEC2:
            begin
                sram.addr_b          = two_operand ? d1 : s2;
                sram.wren_b          = 1'b1;
                compute.update_carry = (opcode == ADDS);
                next_state           = IDLE;
            end

            SETC:
            begin
                compute.load_carry = 1'b1;
                next_state         = IDLE;
            end

            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

// File: verilog/cim_host_port.sv
// Avalon-MM slave side of the compute-in-memory block
// Request acceptance, instruction field capture and read data return

`timescale 1ns/1ps
`include "cim_config.svh"

module cim_host_port
    import cim_pkg::*;
(
    input  logic                            sys_clk_in,
    input  logic                            sys_reset_in,
    input  logic [`CIM_HOST_ADDR_WIDTH-1:0] avalon_address,
    input  logic [`CIM_DATA_WIDTH-1:0]      avalon_writedata,
    input  logic                            avalon_write,
    input  logic                            avalon_read,
    output logic                            avalon_waitrequest,
    output logic [`CIM_DATA_WIDTH-1:0]      avalon_readdata,
    output logic                            avalon_readdatavalid,
    input  logic                            ready,
    input  logic                            readback_strobe,
    input  row_data_t                       rdata_a,
    output logic                            load_start,
    output logic                            exec_start,
    output logic                            read_start,
    output cim_opcode_t                     opcode,
    output row_addr_t                       s1,
    output row_addr_t                       s2,
    output row_addr_t                       d1,
    output row_addr_t                       row_addr,
    output row_data_t                       load_word
);

    cim_opcode_t opcode_q;

    // Address bit 8 selects a direct load over an instruction
    assign load_start = ready && avalon_write && avalon_address[`CIM_ADDR_WIDTH];
    assign exec_start = ready && avalon_write && !avalon_address[`CIM_ADDR_WIDTH];
    assign read_start = ready && avalon_read && !avalon_write;

    assign avalon_waitrequest = !ready;

    // Opcode forwarded in the accepting cycle so the FSM can branch at once
    assign opcode = exec_start ?
                    cim_opcode_t'(avalon_writedata[`CIM_OP_HI:`CIM_OP_LO]) : opcode_q;

    always_ff @(posedge sys_clk_in)
    begin
        if (exec_start)
        begin
            opcode_q <= cim_opcode_t'(avalon_writedata[`CIM_OP_HI:`CIM_OP_LO]);
            s1       <= avalon_writedata[`CIM_S1_HI:`CIM_S1_LO];
            s2       <= avalon_writedata[`CIM_S2_HI:`CIM_S2_LO];
            d1       <= avalon_writedata[`CIM_D1_HI:`CIM_D1_LO];
        end
        if (load_start)
            load_word <= avalon_writedata;
        if (load_start || exec_start || read_start)
            row_addr <= avalon_address[`CIM_ADDR_WIDTH-1:0];
        if (readback_strobe)
            avalon_readdata <= rdata_a;
    end

    always_ff @(posedge sys_clk_in or posedge sys_reset_in)
    begin
        if (sys_reset_in)
            avalon_readdatavalid <= 1'b0;
        else
            avalon_readdatavalid <= readback_strobe;
    end

endmodule

// File: verilog/cim_pkg.sv
// Shared types for the compute-in-memory block
// Row widths, opcodes, combine operations and controller states

`include "cim_config.svh"

package cim_pkg;

    typedef logic [`CIM_ADDR_WIDTH-1:0] row_addr_t;
    typedef logic [`CIM_DATA_WIDTH-1:0] row_data_t;
    typedef logic [4:0]                 shift_amt_t;

    // Host instruction opcodes
    typedef enum logic [7:0] {
        MOVE  = 8'h01,
        ORC   = 8'h03,
        ANDC  = 8'h04,
        XORC  = 8'h05,
        LSHFT = 8'h08,
        RSHFT = 8'h09,
        P_INV = 8'h0E,
        ADDS  = 8'h0F,
        SCIN  = 8'h10
    } cim_opcode_t;

    // Result select for the compute unit
    typedef enum logic [2:0] {
        CMB_PASS,
        CMB_OR,
        CMB_AND,
        CMB_XOR,
        CMB_SHL,
        CMB_SHR,
        CMB_INV,
        CMB_ADD
    } combine_op_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        READ1,
        READ2,
        READ3,
        EXEC1,
        EXEC2,
        SETC
    } ctrl_state_t;

endpackage

// File: verilog/cim_sram_array.sv
// Dual-port synchronous row memory
// Registered reads on both ports, port B write with data select

`timescale 1ns/1ps
`include "cim_config.svh"

module cim_sram_array
    import cim_pkg::*;
(
    input  logic       sys_clk_in,
    cim_sram_if.memory mem,
    input  row_data_t  load_word,
    input  row_data_t  result
);

    row_data_t rows [`CIM_DEPTH];
    row_data_t wdata_b;

    // Host load word or compute result
    assign wdata_b = mem.wsel_load ? load_word : result;

    always_ff @(posedge sys_clk_in)
    begin
        mem.rdata_a <= rows[mem.addr_a];
        mem.rdata_b <= rows[mem.addr_b];
        if (mem.wren_b)
            rows[mem.addr_b] <= wdata_b;
    end

endmodule

// File: verilog/cim_sram_if.sv
// SRAM port bundle between controller and array
// Port A read address, port B read/write address and write controls

`timescale 1ns/1ps

interface cim_sram_if
    import cim_pkg::*;
();

    row_addr_t addr_a;
    row_addr_t addr_b;
    logic      wren_b;
    // High selects the host load word for the port B write
    logic      wsel_load;
    row_data_t rdata_a;
    row_data_t rdata_b;

    modport driver (
        output addr_a,
        output addr_b,
        output wren_b,
        output wsel_load
    );

    modport memory (
        input  addr_a,
        input  addr_b,
        input  wren_b,
        input  wsel_load,
        output rdata_a,
        output rdata_b
    );

endinterface

// File: verilog/cim_top.sv
// Compute-in-memory block top level
// Avalon-MM slave ports, host port, controller, row memory and compute unit

`timescale 1ns/1ps
`include "cim_config.svh"

module cim_top
    import cim_pkg::*;
(
    input  logic                            sys_clk_in,
    input  logic                            sys_reset_in,
    input  logic [`CIM_HOST_ADDR_WIDTH-1:0] avalon_address,
    input  logic [`CIM_DATA_WIDTH-1:0]      avalon_writedata,
    input  logic                            avalon_write,
    input  logic                            avalon_read,
    output logic                            avalon_waitrequest,
    output logic [`CIM_DATA_WIDTH-1:0]      avalon_readdata,
    output logic                            avalon_readdatavalid
);

    logic        ready;
    logic        readback_strobe;
    logic        load_start;
    logic        exec_start;
    logic        read_start;
    cim_opcode_t opcode;
    row_addr_t   s1;
    row_addr_t   s2;
    row_addr_t   d1;
    row_addr_t   row_addr;
    row_data_t   load_word;
    row_data_t   result;

    cim_sram_if    sram_bus ();
    cim_compute_if compute_bus ();

    cim_host_port host_port_i (
        .sys_clk_in           (sys_clk_in),
        .sys_reset_in         (sys_reset_in),
        .avalon_address       (avalon_address),
        .avalon_writedata     (avalon_writedata),
        .avalon_write         (avalon_write),
        .avalon_read          (avalon_read),
        .avalon_waitrequest   (avalon_waitrequest),
        .avalon_readdata      (avalon_readdata),
        .avalon_readdatavalid (avalon_readdatavalid),
        .ready                (ready),
        .readback_strobe      (readback_strobe),
        .rdata_a              (sram_bus.rdata_a),
        .load_start           (load_start),
        .exec_start           (exec_start),
        .read_start           (read_start),
        .opcode               (opcode),
        .s1                   (s1),
        .s2                   (s2),
        .d1                   (d1),
        .row_addr             (row_addr),
        .load_word            (load_word)
    );

    cim_controller controller_i (
        .sys_clk_in      (sys_clk_in),
        .sys_reset_in    (sys_reset_in),
        .load_start      (load_start),
        .exec_start      (exec_start),
        .read_start      (read_start),
        .opcode          (opcode),
        .s1              (s1),
        .s2              (s2),
        .d1              (d1),
        .row_addr        (row_addr),
        .ready           (ready),
        .readback_strobe (readback_strobe),
        .sram            (sram_bus.driver),
        .compute         (compute_bus.command)
    );

    cim_sram_array sram_array_i (
        .sys_clk_in (sys_clk_in),
        .mem        (sram_bus.memory),
        .load_word  (load_word),
        .result     (result)
    );

    cim_compute_unit compute_unit_i (
        .sys_clk_in   (sys_clk_in),
        .sys_reset_in (sys_reset_in),
        .cmd          (compute_bus.unit),
        .rdata_a      (sram_bus.rdata_a),
        .rdata_b      (sram_bus.rdata_b),
        .result       (result)
    );

endmodule
